//--- list.f
hw/qnet_pkg.sv
hw/link_pkg.sv
hw/rx_packet_capture.sv
hw/packet_router.sv
hw/tx_packet_sender.sv
hw/busy_timer.sv
hw/net_ctrl_fsm.sv
hw/net_ctrl_top.sv
bench/net_ctrl_asserts.sv
bench/net_ctrl_tb.sv

//--- Bender.yml
package:
  name: net_ctrl

sources:
  - hw/qnet_pkg.sv
  - hw/link_pkg.sv
  - hw/rx_packet_capture.sv
  - hw/packet_router.sv
  - hw/tx_packet_sender.sv
  - hw/busy_timer.sv
  - hw/net_ctrl_fsm.sv
  - hw/net_ctrl_top.sv
  - target: test
    files:
      - bench/net_ctrl_asserts.sv
      - bench/net_ctrl_tb.sv

//--- bench/net_ctrl_tb.sv
`default_nettype none

module net_ctrl_tb
   import qnet_pkg::*, link_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_ROWS    = 13;
   localparam int CYCLE_LIMIT = NUM_ROWS * 200;
   localparam int SRC_A       = 0;
   localparam int SRC_B       = 1;
   localparam int SRC_LOCAL   = 2;
   localparam int K_CMD       = 0;   // command to the local side
   localparam int K_SEND      = 1;   // two beats on one link
   localparam int K_NONE      = 2;   // dropped
   localparam int K_TIMEOUT   = 3;

   logic      user_clk, user_rst;
   node_id_t  own_id_i;
   logic      link_a_up_i, link_b_up_i;
   logic      a_rx_valid_i, a_rx_last_i, a_rx_ready_o;
   beat_t     a_rx_data_i;
   logic      a_tx_valid_o, a_tx_last_o, a_tx_ready_i;
   beat_t     a_tx_data_o;
   logic      b_rx_valid_i, b_rx_last_i, b_rx_ready_o;
   beat_t     b_rx_data_i;
   logic      b_tx_valid_o, b_tx_last_o, b_tx_ready_i;
   beat_t     b_tx_data_o;
   logic      tx_req_valid_i, tx_req_ready_o;
   link_sel_t tx_req_ch_i;
   header_t   tx_req_header_i;
   beat_t     tx_req_data_i;
   logic      cmd_valid_o, cmd_ready_i, ready_o;
   link_sel_t cmd_ch_o;
   header_t   cmd_header_o;
   beat_t     cmd_data_o;

   // stimulus table
   string       t_name [NUM_ROWS];
   int          t_src  [NUM_ROWS];
   logic        t_ch   [NUM_ROWS];
   logic [63:0] t_hdr  [NUM_ROWS];
   logic [63:0] t_data [NUM_ROWS];
   int          t_kind [NUM_ROWS];
   int          n_rows = 0;

   // what the DUT handed out during one row
   logic [63:0] beat_val  [2][4];
   logic        beat_last [2][4];
   int          beat_cnt  [2];
   int          cmd_cnt;
   logic        cmd_ch;
   logic [63:0] cmd_hdr, cmd_dat;
   logic        saw_down;     // ready_o seen low
   logic        stall;        // hold tx_ready low
   integer      seed;
   int          n_checks = 0;
   int          n_errors = 0;
   int          cycle_cnt;

   net_ctrl_top #(.TIMEOUT_CYCLES(64)) dut0 (.*);

   initial begin
      user_clk = 1'b0;
      forever #20 user_clk = ~user_clk;
   end

   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < CYCLE_LIMIT) begin
         @(posedge user_clk);
         cycle_cnt++;
      end
      $display("DUT did not finish the table within %0d cycles", CYCLE_LIMIT);
      $display("checks: %0d, errors: %0d", n_checks, n_errors + 1);
      $display("Verification failed");
      $finish;
   end

   //////////////////////////////////////////////////
   // reference model and helpers

   function automatic logic [63:0] make_hdr(input logic [3:0] op, input logic [9:0] dst,
                                            input logic [9:0] src, input logic [9:0] step,
                                            input logic [19:0] pay);
      return {4'h9, op, 6'h2a, dst, src, step, pay};
   endfunction

   // forwarded header with step field 29..20 one higher
   function automatic logic [63:0] bump_step(input logic [63:0] h);
      logic [63:0] r;
      r = h;
      r[29:20] = h[29:20] + 10'd1;
      return r;
   endfunction

   task automatic add_row(input string name, input int src, input logic ch,
                          input logic [63:0] hdr, input logic [63:0] data, input int kind);
      t_name[n_rows] = name;
      t_src[n_rows]  = src;
      t_ch[n_rows]   = ch;
      t_hdr[n_rows]  = hdr;
      t_data[n_rows] = data;
      t_kind[n_rows] = kind;
      n_rows++;
   endtask

   task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
      n_checks++;
      if (exp !== act) begin
         n_errors++;
         $display("Fail %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic record_beat(input int link, input logic [63:0] d, input logic last);
      if (beat_cnt[link] < 4) begin
         beat_val[link][beat_cnt[link]]  = d;
         beat_last[link][beat_cnt[link]] = last;
      end
      beat_cnt[link]++;
   endtask

   // new ready values and the handshakes due at the next rising edge
   task automatic tick();
      @(negedge user_clk);
      cmd_ready_i  = (($random(seed) % 4) != 0);
      a_tx_ready_i = (($random(seed) % 4) != 0) && !stall;
      b_tx_ready_i = (($random(seed) % 4) != 0) && !stall;
      if (!ready_o)
         saw_down = 1'b1;
      if (cmd_valid_o && cmd_ready_i) begin
         cmd_cnt++;
         cmd_ch  = cmd_ch_o;
         cmd_hdr = cmd_header_o;
         cmd_dat = cmd_data_o;
      end
      if (a_tx_valid_o && a_tx_ready_i)
         record_beat(SRC_A, a_tx_data_o, a_tx_last_o);
      if (b_tx_valid_o && b_tx_ready_i)
         record_beat(SRC_B, b_tx_data_o, b_tx_last_o);
   endtask

   task automatic send_beat(input int link, input logic [63:0] d, input logic last);
      if (link == SRC_A) begin
         a_rx_valid_i = 1'b1;
         a_rx_data_i  = d;
         a_rx_last_i  = last;
      end else begin
         b_rx_valid_i = 1'b1;
         b_rx_data_i  = d;
         b_rx_last_i  = last;
      end
      while (!((link == SRC_A) ? a_rx_ready_o : b_rx_ready_o))
         tick();
      tick();
      a_rx_valid_i = 1'b0;
      b_rx_valid_i = 1'b0;
   endtask

   task automatic check_row(input int i);
      int          tgt;
      logic [63:0] exp_hdr;
      string       n;
      n = t_name[i];
      case (t_kind[i])
         K_CMD: begin
            check_val({n, " cmd count"}, 1, cmd_cnt);
            check_val({n, " cmd_ch"}, t_src[i], cmd_ch);
            check_val({n, " cmd_header"}, t_hdr[i], cmd_hdr);
            check_val({n, " cmd_data"}, t_data[i], cmd_dat);
            check_val({n, " tx beats"}, 0, beat_cnt[0] + beat_cnt[1]);
         end
         K_SEND: begin
            if (t_src[i] == SRC_LOCAL) begin   // local request goes out unchanged
               tgt     = t_ch[i];
               exp_hdr = t_hdr[i];
            end else begin                     // forward on the opposite link
               tgt     = 1 - t_src[i];
               exp_hdr = bump_step(t_hdr[i]);
            end
            check_val({n, " beats on target link"}, 2, beat_cnt[tgt]);
            check_val({n, " beats on other link"}, 0, beat_cnt[1 - tgt]);
            check_val({n, " header beat"}, exp_hdr, beat_val[tgt][0]);
            check_val({n, " header last"}, 0, beat_last[tgt][0]);
            check_val({n, " data beat"}, t_data[i], beat_val[tgt][1]);
            check_val({n, " data last"}, 1, beat_last[tgt][1]);
            check_val({n, " cmd count"}, 0, cmd_cnt);
         end
         default: begin
            check_val({n, " cmd count"}, 0, cmd_cnt);
            check_val({n, " tx beats"}, 0, beat_cnt[0] + beat_cnt[1]);
         end
      endcase
      if (t_kind[i] == K_TIMEOUT) begin
         check_val({n, " ready_o fell"}, 1, saw_down);
         check_val({n, " tx_valid dropped"}, 0, {a_tx_valid_o, b_tx_valid_o});
      end else begin
         check_val({n, " ready_o held"}, 0, saw_down);
      end
   endtask

   task automatic apply_row(input int i);
      while (!ready_o)
         tick();
      stall       = (t_kind[i] == K_TIMEOUT);
      cmd_cnt     = 0;
      beat_cnt[0] = 0;
      beat_cnt[1] = 0;
      saw_down    = 1'b0;
      if (t_src[i] == SRC_LOCAL) begin
         tx_req_valid_i  = 1'b1;
         tx_req_ch_i     = link_sel_t'(t_ch[i]);
         tx_req_header_i = t_hdr[i];
         tx_req_data_i   = t_data[i];
         while (!tx_req_ready_o)
            tick();
         tick();
         tx_req_valid_i = 1'b0;
      end else begin
         send_beat(t_src[i], t_hdr[i], 1'b0);
         send_beat(t_src[i], t_data[i], 1'b1);
         check_val({t_name[i], " rx_ready while held"}, 0,
                   (t_src[i] == SRC_A) ? a_rx_ready_o : b_rx_ready_o);
      end
      while (!tx_req_ready_o)   // idle again with nothing held
         tick();
      check_row(i);
      stall = 1'b0;
   endtask

   //////////////////////////////////////////////////
   // main sequence

   initial begin
      seed            = 12812;
      user_rst        = 1'b1;
      own_id_i        = 10'd5;
      link_a_up_i     = 1'b0;
      link_b_up_i     = 1'b0;
      a_rx_valid_i    = 1'b0;
      a_rx_data_i     = '0;
      a_rx_last_i     = 1'b0;
      a_tx_ready_i    = 1'b0;
      b_rx_valid_i    = 1'b0;
      b_rx_data_i     = '0;
      b_rx_last_i     = 1'b0;
      b_tx_ready_i    = 1'b0;
      tx_req_valid_i  = 1'b0;
      tx_req_ch_i     = LINK_A;
      tx_req_header_i = '0;
      tx_req_data_i   = '0;
      cmd_ready_i     = 1'b0;
      stall           = 1'b0;
      saw_down        = 1'b0;
      cmd_cnt         = 0;
      beat_cnt[0]     = 0;
      beat_cnt[1]     = 0;

      add_row("a_to_own", SRC_A, 1'b0, make_hdr(4'h3, 10'd5, 10'd12, 10'd2, 20'h1a2b3),
              64'h0123_4567_89ab_cdef, K_CMD);
      add_row("b_broadcast", SRC_B, 1'b0, make_hdr(4'h1, 10'h3ff, 10'd7, 10'd6, 20'h00c0f),
              64'hfeed_0000_beef_0001, K_CMD);
      add_row("a_forward_step3", SRC_A, 1'b0, make_hdr(4'h2, 10'd9, 10'd2, 10'd3, 20'h55555),
              64'h1111_2222_3333_4444, K_SEND);
      add_row("a_step_max_drop", SRC_A, 1'b0, make_hdr(4'h2, 10'd9, 10'd2, 10'h3ff, 20'h0aaaa),
              64'hdead_dead_dead_dead, K_NONE);
      add_row("b_forward_after_drop", SRC_B, 1'b0,
              make_hdr(4'h4, 10'd9, 10'd11, 10'd0, 20'h12345), 64'h5555_6666_7777_8888, K_SEND);
      add_row("b_own_returned", SRC_B, 1'b0, make_hdr(4'h5, 10'd20, 10'd5, 10'd8, 20'hfffff),
              64'h0f0f_0f0f_f0f0_f0f0, K_CMD);
      for (int k = 0; k < 4; k++)
         add_row($sformatf("local_random_%0d", k), SRC_LOCAL, k[0] ^ k[1],
                 {$random(seed), $random(seed)}, {$random(seed), $random(seed)}, K_SEND);
      add_row("a_stall_timeout", SRC_A, 1'b0, make_hdr(4'h6, 10'd9, 10'd3, 10'd1, 20'h0beef),
              64'hcafe_cafe_cafe_cafe, K_TIMEOUT);
      add_row("a_forward_after_timeout", SRC_A, 1'b0,
              make_hdr(4'h7, 10'd9, 10'd3, 10'd7, 20'h76543), 64'h9999_aaaa_bbbb_cccc, K_SEND);
      add_row("b_to_own_after_timeout", SRC_B, 1'b0,
              make_hdr(4'h8, 10'd5, 10'd30, 10'd4, 20'h00001), 64'h1234_0000_0000_4321, K_CMD);

      repeat (10) @(negedge user_clk);
      user_rst = 1'b0;
      tick();
      check_val("reset ready_o", 0, ready_o);
      check_val("reset a_tx_valid", 0, a_tx_valid_o);
      check_val("reset b_tx_valid", 0, b_tx_valid_o);
      check_val("reset cmd_valid", 0, cmd_valid_o);
      check_val("reset tx_req_ready", 0, tx_req_ready_o);
      repeat (3) tick();
      check_val("links down ready_o", 0, ready_o);   // not ready until both links up
      link_a_up_i = 1'b1;
      link_b_up_i = 1'b1;
      while (!ready_o)
         tick();

      for (int i = 0; i < n_rows; i++)
         apply_row(i);

      $display("checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- bench/net_ctrl_asserts.sv
`default_nettype none

module net_ctrl_asserts (
   input logic user_clk,
   input logic user_rst,
   input logic a_busy_i,      // same as link A tx_valid
   input logic b_busy_i,      // same as link B tx_valid
   input logic a_load_i,
   input logic b_load_i,
   input logic abort_i,
   input logic in_send_i,
   input logic fault_i,
   input logic cmd_valid_i,
   input logic cmd_ready_i,
   input logic cmd_ch_i
);

   timeunit 1ns;
   timeprecision 1ps;

   //////////////////////////////////////////////////
   // tx valid held until the link takes the beat

   a_no_reload: assert property (@(posedge user_clk) disable iff (user_rst)
      a_busy_i |-> !a_load_i)
      else $error("link A sender loaded again while its valid was up");

   b_no_reload: assert property (@(posedge user_clk) disable iff (user_rst)
      b_busy_i |-> !b_load_i)
      else $error("link B sender loaded again while its valid was up");

   // valid only falls after a send with ready, or on abort
   a_valid_held: assert property (@(posedge user_clk) disable iff (user_rst)
      $fell(a_busy_i) |-> $past(in_send_i) || $past(abort_i))
      else $error("link A tx_valid dropped outside a send");

   b_valid_held: assert property (@(posedge user_clk) disable iff (user_rst)
      $fell(b_busy_i) |-> $past(in_send_i) || $past(abort_i))
      else $error("link B tx_valid dropped outside a send");

   one_link_at_a_time: assert property (@(posedge user_clk) disable iff (user_rst)
      !(a_busy_i && b_busy_i))
      else $error("both links transmitting at once");

   //////////////////////////////////////////////////
   // command held under back-pressure

   cmd_stable: assert property (@(posedge user_clk) disable iff (user_rst)
      cmd_valid_i && !cmd_ready_i && !fault_i |=> cmd_valid_i && $stable(cmd_ch_i))
      else $error("command changed before cmd_ready");

endmodule

bind net_ctrl_fsm net_ctrl_asserts fsm_chk (
   .user_clk    (user_clk),
   .user_rst    (user_rst),
   .a_busy_i    (a_busy_i),
   .b_busy_i    (b_busy_i),
   .a_load_i    (a_load_o),
   .b_load_i    (b_load_o),
   .abort_i     (abort_o),
   .in_send_i   (state_q == SEND),
   .fault_i     (fault),
   .cmd_valid_i (cmd_valid_o),
   .cmd_ready_i (cmd_ready_i),
   .cmd_ch_i    (cmd_ch_o)
);

`default_nettype wire

//--- hw/net_ctrl_top.sv
`default_nettype none

module net_ctrl_top
   import qnet_pkg::*, link_pkg::*;
#(
   parameter int unsigned TIMEOUT_CYCLES = 512
) (
   input  logic      user_clk,
   input  logic      user_rst,
   input  node_id_t  own_id_i,
   input  logic      link_a_up_i,
   input  logic      link_b_up_i,
   // link A receive and transmit
   input  logic      a_rx_valid_i,
   input  beat_t     a_rx_data_i,
   input  logic      a_rx_last_i,
   output logic      a_rx_ready_o,
   output logic      a_tx_valid_o,
   output beat_t     a_tx_data_o,
   output logic      a_tx_last_o,
   input  logic      a_tx_ready_i,
   // link B receive and transmit
   input  logic      b_rx_valid_i,
   input  beat_t     b_rx_data_i,
   input  logic      b_rx_last_i,
   output logic      b_rx_ready_o,
   output logic      b_tx_valid_o,
   output beat_t     b_tx_data_o,
   output logic      b_tx_last_o,
   input  logic      b_tx_ready_i,
   // local transmit request
   input  logic      tx_req_valid_i,
   input  link_sel_t tx_req_ch_i,
   input  header_t   tx_req_header_i,
   input  beat_t     tx_req_data_i,
   output logic      tx_req_ready_o,
   // local command
   output logic      cmd_valid_o,
   output link_sel_t cmd_ch_o,
   output header_t   cmd_header_o,
   output beat_t     cmd_data_o,
   input  logic      cmd_ready_i,
   output logic      ready_o
);

   logic      a_pkt_valid, b_pkt_valid;
   logic      a_release, b_release;
   header_t   a_pkt_header, b_pkt_header;
   beat_t     a_pkt_data, b_pkt_data;
   link_sel_t sel;
   logic      is_local, is_drop;
   header_t   fwd_header;
   beat_t     pkt_data;
   logic      a_load, b_load, load_local;
   logic      a_busy, b_busy, abort;
   logic      busy, expired;
   header_t   snd_header;
   beat_t     snd_data;

   //////////////////////////////////////////////////
   // receive side

   rx_packet_capture rx_a (
      .user_clk, .user_rst,
      .rx_valid_i   (a_rx_valid_i),
      .rx_data_i    (a_rx_data_i),
      .rx_last_i    (a_rx_last_i),
      .rx_ready_o   (a_rx_ready_o),
      .pkt_valid_o  (a_pkt_valid),
      .pkt_header_o (a_pkt_header),
      .pkt_data_o   (a_pkt_data),
      .release_i    (a_release)
   );

   rx_packet_capture rx_b (
      .user_clk, .user_rst,
      .rx_valid_i   (b_rx_valid_i),
      .rx_data_i    (b_rx_data_i),
      .rx_last_i    (b_rx_last_i),
      .rx_ready_o   (b_rx_ready_o),
      .pkt_valid_o  (b_pkt_valid),
      .pkt_header_o (b_pkt_header),
      .pkt_data_o   (b_pkt_data),
      .release_i    (b_release)
   );

   packet_router router (
      .sel_i        (sel),
      .a_header_i   (a_pkt_header),
      .a_data_i     (a_pkt_data),
      .b_header_i   (b_pkt_header),
      .b_data_i     (b_pkt_data),
      .own_id_i     (own_id_i),
      .is_local_o   (is_local),
      .is_drop_o    (is_drop),
      .header_o     (cmd_header_o),   // command carries the held packet as is
      .fwd_header_o_unused_guard (),
      .fwd_header_o (fwd_header),
      .data_o       (pkt_data)
   );

   assign cmd_data_o = pkt_data;

   //////////////////////////////////////////////////
   // transmit side

   assign snd_header = load_local ? tx_req_header_i : fwd_header;
   assign snd_data   = load_local ? tx_req_data_i : pkt_data;

   tx_packet_sender tx_a (
      .user_clk, .user_rst,
      .load_i     (a_load),
      .header_i   (snd_header),
      .data_i     (snd_data),
      .busy_o     (a_busy),
      .tx_valid_o (a_tx_valid_o),
      .tx_data_o  (a_tx_data_o),
      .tx_last_o  (a_tx_last_o),
      .tx_ready_i (a_tx_ready_i),
      .abort_i    (abort)
   );

   tx_packet_sender tx_b (
      .user_clk, .user_rst,
      .load_i     (b_load),
      .header_i   (snd_header),
      .data_i     (snd_data),
      .busy_o     (b_busy),
      .tx_valid_o (b_tx_valid_o),
      .tx_data_o  (b_tx_data_o),
      .tx_last_o  (b_tx_last_o),
      .tx_ready_i (b_tx_ready_i),
      .abort_i    (abort)
   );

   //////////////////////////////////////////////////
   // control

   net_ctrl_fsm fsm (
      .user_clk, .user_rst,
      .link_a_up_i, .link_b_up_i,
      .a_pkt_valid_i  (a_pkt_valid),
      .b_pkt_valid_i  (b_pkt_valid),
      .a_release_o    (a_release),
      .b_release_o    (b_release),
      .sel_o          (sel),
      .is_local_i     (is_local),
      .is_drop_i      (is_drop),
      .tx_req_valid_i, .tx_req_ch_i, .tx_req_ready_o,
      .a_load_o       (a_load),
      .b_load_o       (b_load),
      .load_local_o   (load_local),
      .a_busy_i       (a_busy),
      .b_busy_i       (b_busy),
      .abort_o        (abort),
      .cmd_valid_o, .cmd_ch_o, .cmd_ready_i,
      .busy_o         (busy),
      .expired_i      (expired),
      .ready_o
   );

   busy_timer #(
      .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
   ) timer (
      .user_clk, .user_rst,
      .busy_i    (busy),
      .expired_o (expired)
   );

endmodule

`default_nettype wire

//--- hw/net_ctrl_fsm.sv
`default_nettype none

module net_ctrl_fsm
   import link_pkg::*;
(
   input  logic      user_clk,
   input  logic      user_rst,
   input  logic      link_a_up_i,
   input  logic      link_b_up_i,
   input  logic      a_pkt_valid_i,
   input  logic      b_pkt_valid_i,
   output logic      a_release_o,
   output logic      b_release_o,
   output link_sel_t sel_o,
   input  logic      is_local_i,
   input  logic      is_drop_i,
   input  logic      tx_req_valid_i,
   input  link_sel_t tx_req_ch_i,
   output logic      tx_req_ready_o,
   output logic      a_load_o,
   output logic      b_load_o,
   output logic      load_local_o,
   input  logic      a_busy_i,
   input  logic      b_busy_i,
   output logic      abort_o,
   output logic      cmd_valid_o,
   output link_sel_t cmd_ch_o,
   input  logic      cmd_ready_i,
   output logic      busy_o,
   input  logic      expired_i,
   output logic      ready_o
);

   typedef enum logic [2:0] {
      NOT_RDY, IDLE, DECIDE, COMMAND, SEND, WAIT_SENT
   } state_t;

   state_t    state_q, state_d;
   link_sel_t sel_q;       // link of the held packet in work
   link_sel_t tgt_q;       // sender being waited on
   link_sel_t tgt_d;
   logic      from_rx_q;   // work item is a received packet
   logic      ready_q;
   logic      links_ok;
   logic      fault;
   logic      req_fire;
   logic      load_en;
   logic      rel;
   logic      tgt_busy;

   assign links_ok       = link_a_up_i && link_b_up_i;
   assign fault          = !links_ok || expired_i;
   assign busy_o         = (state_q != IDLE) && (state_q != NOT_RDY);
   assign tx_req_ready_o = (state_q == IDLE) && links_ok && !a_pkt_valid_i && !b_pkt_valid_i;
   assign req_fire       = tx_req_valid_i && tx_req_ready_o;
   assign tgt_busy       = (tgt_q == LINK_A) ? a_busy_i : b_busy_i;

   //////////////////////////////////////////////////
   // sender loads, local request or forward

   always_comb begin
      load_en = req_fire || ((state_q == DECIDE) && !is_local_i && !is_drop_i);
      if (state_q == IDLE)
         tgt_d = tx_req_ch_i;
      else
         tgt_d = (sel_q == LINK_A) ? LINK_B : LINK_A;   // opposite link
   end

   assign a_load_o     = load_en && (tgt_d == LINK_A);
   assign b_load_o     = load_en && (tgt_d == LINK_B);
   assign load_local_o = (state_q == IDLE);

   //////////////////////////////////////////////////
   // next state

   always_comb begin
      state_d = state_q;
      case (state_q)
         NOT_RDY: if (links_ok) state_d = IDLE;
         IDLE: begin
            if (a_pkt_valid_i || b_pkt_valid_i)
               state_d = DECIDE;
            else if (req_fire)
               state_d = SEND;
         end
         DECIDE: begin
            if (is_local_i)
               state_d = COMMAND;
            else if (is_drop_i)
               state_d = IDLE;
            else
               state_d = SEND;
         end
         COMMAND:   if (cmd_ready_i) state_d = IDLE;
         SEND:      if (!tgt_busy) state_d = WAIT_SENT;   // both beats gone
         WAIT_SENT: state_d = IDLE;
         default:   state_d = NOT_RDY;
      endcase
      if (fault)
         state_d = NOT_RDY;   // timeout or link lost
   end

   // packet is given back when its work ends or is cut short
   always_comb begin
      rel = from_rx_q && (((state_q == DECIDE) && is_drop_i)
                          || ((state_q == COMMAND) && cmd_ready_i)
                          || (state_q == WAIT_SENT)
                          || (fault && busy_o));
   end

   always_ff @(posedge user_clk or posedge user_rst) begin
      if (user_rst) begin
         state_q   <= NOT_RDY;
         sel_q     <= LINK_A;
         tgt_q     <= LINK_A;
         from_rx_q <= 1'b0;
         ready_q   <= 1'b0;
      end else begin
         state_q <= state_d;
         ready_q <= (state_q != NOT_RDY) && !fault;
         if (state_q == IDLE) begin
            if (a_pkt_valid_i) begin   // link A first
               sel_q     <= LINK_A;
               from_rx_q <= 1'b1;
            end else if (b_pkt_valid_i) begin
               sel_q     <= LINK_B;
               from_rx_q <= 1'b1;
            end else if (req_fire) begin
               from_rx_q <= 1'b0;
            end
         end
         if (load_en)
            tgt_q <= tgt_d;
      end
   end

   assign a_release_o = rel && (sel_q == LINK_A);
   assign b_release_o = rel && (sel_q == LINK_B);
   assign sel_o       = sel_q;
   assign abort_o     = fault && (state_q != NOT_RDY);
   assign cmd_valid_o = (state_q == COMMAND);
   assign cmd_ch_o    = sel_q;
   assign ready_o     = ready_q;

endmodule

`default_nettype wire

//--- hw/busy_timer.sv
`default_nettype none

module busy_timer #(
   parameter int unsigned TIMEOUT_CYCLES = 512
) (
   input  logic user_clk,
   input  logic user_rst,
   input  logic busy_i,
   output logic expired_o
);

   localparam int unsigned       CNT_W = $clog2(TIMEOUT_CYCLES + 1);
   localparam logic [CNT_W-1:0] LIMIT = CNT_W'(TIMEOUT_CYCLES);

   logic [CNT_W-1:0] cnt_q;   // busy cycles before this one

   always_ff @(posedge user_clk or posedge user_rst) begin
      if (user_rst)
         cnt_q <= '0;
      else if (!busy_i)
         cnt_q <= '0;
      else if (cnt_q != LIMIT)   // saturate so the pulse fires once
         cnt_q <= cnt_q + 1'b1;
   end

   assign expired_o = busy_i && (cnt_q == LIMIT - 1'b1);

endmodule

`default_nettype wire

//--- hw/tx_packet_sender.sv
`default_nettype none

module tx_packet_sender
   import qnet_pkg::*, link_pkg::*;
(
   input  logic    user_clk,
   input  logic    user_rst,
   input  logic    load_i,
   input  header_t header_i,
   input  beat_t   data_i,
   output logic    busy_o,
   output logic    tx_valid_o,
   output beat_t   tx_data_o,
   output logic    tx_last_o,
   input  logic    tx_ready_i,
   input  logic    abort_i
);

   localparam int unsigned       CNT_W     = $clog2(BEATS_PER_PACKET);
   localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(BEATS_PER_PACKET - 1);

   logic             busy_q;
   logic [CNT_W-1:0] beat_q;   // beat on the link now
   header_t          hdr_q;
   beat_t            data_q;

   always_ff @(posedge user_clk or posedge user_rst) begin
      if (user_rst) begin
         busy_q <= 1'b0;
         beat_q <= '0;
      end else if (abort_i) begin   // abandon whatever is left
         busy_q <= 1'b0;
         beat_q <= '0;
      end else if (load_i) begin
         busy_q <= 1'b1;
         beat_q <= '0;
      end else if (busy_q && tx_ready_i) begin
         if (beat_q == LAST_BEAT) begin
            busy_q <= 1'b0;
            beat_q <= '0;
         end else begin
            beat_q <= beat_q + 1'b1;
         end
      end
   end

   always_ff @(posedge user_clk) begin
      if (load_i) begin
         hdr_q  <= header_i;
         data_q <= data_i;
      end
   end

   assign busy_o     = busy_q;
   assign tx_valid_o = busy_q;
   assign tx_data_o  = (beat_q == '0) ? beat_t'(hdr_q) : data_q;   // header goes first
   assign tx_last_o  = busy_q && (beat_q == LAST_BEAT);

endmodule

`default_nettype wire

//--- hw/packet_router.sv
`default_nettype none

module packet_router
   import qnet_pkg::*, link_pkg::*;
(
   input  link_sel_t sel_i,
   input  header_t   a_header_i,
   input  beat_t     a_data_i,
   input  header_t   b_header_i,
   input  beat_t     b_data_i,
   input  node_id_t  own_id_i,
   output logic      is_local_o,
   output logic      is_drop_o,
   output header_t   header_o,
   output beat_t     fwd_header_o_unused_guard,
   output header_t   fwd_header_o,
   output beat_t     data_o
);

   header_t hdr;
   logic    id_set;      // zero id means unassigned node
   logic    dst_own;
   logic    dst_all;
   logic    src_own;

   //////////////////////////////////////////////////
   // held packet select

   always_comb begin
      if (sel_i == LINK_B) begin
         hdr    = b_header_i;
         data_o = b_data_i;
      end else begin
         hdr    = a_header_i;
         data_o = a_data_i;
      end
   end

   //////////////////////////////////////////////////
   // header decode

   always_comb begin
      id_set     = (own_id_i != '0);
      dst_own    = id_set && (hdr.dst == own_id_i);
      dst_all    = (hdr.dst == BROADCAST_ID);
      src_own    = (hdr.src == own_id_i);   // our own packet came back around
      is_local_o = dst_own || dst_all || src_own;
      is_drop_o  = !is_local_o && id_set && (hdr.step == STEP_MAX);
   end

   always_comb begin
      fwd_header_o      = hdr;
      fwd_header_o.step = hdr.step + 1'b1;   // one more hop
   end

   assign header_o                  = hdr;
   assign fwd_header_o_unused_guard = beat_t'(fwd_header_o);

endmodule

`default_nettype wire

//--- hw/rx_packet_capture.sv
`default_nettype none

module rx_packet_capture
   import qnet_pkg::*, link_pkg::*;
(
   input  logic    user_clk,
   input  logic    user_rst,
   input  logic    rx_valid_i,
   input  beat_t   rx_data_i,
   input  logic    rx_last_i,
   output logic    rx_ready_o,
   output logic    pkt_valid_o,
   output header_t pkt_header_o,
   output beat_t   pkt_data_o,
   input  logic    release_i
);

   logic    have_hdr_q;    // header stored, waiting for data
   logic    pkt_valid_q;
   logic    beat_fire;
   header_t hdr_q;
   beat_t   data_q;

   assign rx_ready_o = !pkt_valid_q;   // stall link while a packet is held
   assign beat_fire  = rx_valid_i && rx_ready_o;

   always_ff @(posedge user_clk or posedge user_rst) begin
      if (user_rst) begin
         have_hdr_q  <= 1'b0;
         pkt_valid_q <= 1'b0;
      end else begin
         if (release_i)
            pkt_valid_q <= 1'b0;
         if (beat_fire) begin
            if (!have_hdr_q) begin
               have_hdr_q <= 1'b1;
            end else if (rx_last_i) begin   // data without last is skipped
               have_hdr_q  <= 1'b0;
               pkt_valid_q <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge user_clk) begin
      if (beat_fire && !have_hdr_q)
         hdr_q <= rx_data_i;
      if (beat_fire && have_hdr_q && rx_last_i)
         data_q <= rx_data_i;
   end

   assign pkt_valid_o  = pkt_valid_q;
   assign pkt_header_o = hdr_q;
   assign pkt_data_o   = data_q;

endmodule

`default_nettype wire

//--- hw/link_pkg.sv
`default_nettype none

package link_pkg;

   typedef logic [63:0] beat_t;   // one word on the link

   // link A is channel 0, link B is channel 1
   typedef enum logic {
      LINK_A = 1'b0,
      LINK_B = 1'b1
   } link_sel_t;

   localparam int unsigned BEATS_PER_PACKET = 2;   // header + data

endpackage

`default_nettype wire

//--- hw/qnet_pkg.sv
`default_nettype none

package qnet_pkg;

   //////////////////////////////////////////////////
   // node addressing and hop count

   typedef logic [9:0] node_id_t;   // ring node address
   typedef logic [9:0] step_t;      // hops taken so far

   localparam node_id_t BROADCAST_ID = '1;   // all ones, send to all
   localparam step_t    STEP_MAX     = '1;   // last hop allowed

   //////////////////////////////////////////////////
   // header beat layout, msb first

   typedef struct packed {
      logic [3:0]  payload_hi;   // 63..60
      logic [3:0]  opcode;       // 59..56
      logic [5:0]  flags;        // 55..50
      node_id_t    dst;          // 49..40
      node_id_t    src;          // 39..30
      step_t       step;         // 29..20
      logic [19:0] payload_lo;   // 19..0
   } header_t;

endpackage

`default_nettype wire
